// ==== design/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  rv_core_pkg::word_t     instr,
    output logic                   wb_valid,
    output rv_core_pkg::reg_addr_t wb_rd,
    output rv_core_pkg::word_t     wb_data
);
    import rv_core_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    wb_t       mem_fwd;
    wb_t       mem_wb;

    rv_decode_stage decode_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .id_ex       (id_ex)
    );

    rv_register_file register_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wr       (mem_wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_execute_stage execute_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .id_ex   (id_ex),
        .mem_fwd (mem_fwd),
        .wb_fwd  (mem_wb),
        .ex_mem  (ex_mem)
    );

    rv_memory_stage memory_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .ex_mem  (ex_mem),
        .mem_fwd (mem_fwd),
        .mem_wb  (mem_wb)
    );

    // Writeback strobe straight from the MEM/WB register
    assign wb_valid = mem_wb.valid;
    assign wb_rd    = mem_wb.rd;
    assign wb_data  = mem_wb.data;

endmodule

`default_nettype wire

// ==== design/rv_core_config.svh ====
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Data path width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_REG_COUNT 32

// Data memory depth in words
`define RV_DMEM_WORDS 256

// Word index width, log2 of the depth
`define RV_DMEM_ADDR_BITS 8

`endif

// ==== design/rv_core_pkg.sv ====
`default_nettype none

`include "rv_core_config.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_addr_t;

    // Major opcodes handled by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Zero feeds operand A for LUI
    typedef enum logic {
        SRC_A_RS1,
        SRC_A_ZERO
    } src_a_sel_e;

    typedef enum logic {
        SRC_B_RS2,
        SRC_B_IMM
    } src_b_sel_e;

    // mem_size is funct3, bit 2 set means unsigned load
    typedef struct packed {
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        src_a_sel_e src_a_sel;
        src_b_sel_e src_b_sel;
        alu_op_e    alu_op;
        logic [2:0] mem_size;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic       valid;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic [2:0] mem_size;
        reg_addr_t  rd;
        word_t      alu_result;
        word_t      store_data;
    } ex_mem_t;

    // Valid only for a real write to a nonzero register
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

// ==== design/rv_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  rv_core_pkg::word_t     instr,
    output rv_core_pkg::reg_addr_t rs1_addr,
    output rv_core_pkg::reg_addr_t rs2_addr,
    input  rv_core_pkg::word_t     rs1_data,
    input  rv_core_pkg::word_t     rs2_data,
    output rv_core_pkg::id_ex_t    id_ex
);
    import rv_core_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    reg_addr_t  rd;
    word_t      i_imm;
    word_t      s_imm;
    word_t      u_imm;
    alu_op_e    alu_func;
    ctrl_t      ctrl;
    word_t      imm;
    logic       supported;
    id_ex_t     id_ex_d;

    assign opcode   = opcode_e'(instr[6:0]);
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign u_imm = {instr[31:12], 12'b0};

    // Funct7 bit 5 and the SRAI immediate bit 10 are both instr[30]
    always_comb begin
        case (funct3)
            3'b000:  alu_func = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_func = ALU_SLL;
            3'b010:  alu_func = ALU_SLT;
            3'b011:  alu_func = ALU_SLTU;
            3'b100:  alu_func = ALU_XOR;
            3'b101:  alu_func = instr[30] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_func = ALU_OR;
            default: alu_func = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl           = '0;
        ctrl.mem_size  = funct3;
        ctrl.alu_op    = ALU_ADD;
        ctrl.src_a_sel = SRC_A_RS1;
        ctrl.src_b_sel = SRC_B_IMM;
        imm            = i_imm;
        supported      = 1'b1;

        case (opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_b_sel = SRC_B_RS2;
                ctrl.alu_op    = alu_func;
            end
            OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_func;
            end
            OPC_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_a_sel = SRC_A_ZERO;
                imm            = u_imm;
            end
            OPC_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            OPC_STORE: begin
                ctrl.mem_write = 1'b1;
                imm            = s_imm;
            end
            default: begin
                supported = 1'b0;
            end
        endcase

        // Results aimed at x0 are dropped here
        if (rd == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    always_comb begin
        id_ex_d.valid    = instr_valid && supported;
        id_ex_d.ctrl     = ctrl;
        id_ex_d.rs1      = rs1_addr;
        id_ex_d.rs2      = rs2_addr;
        id_ex_d.rd       = rd;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.imm      = imm;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_core_pkg::id_ex_t  id_ex,
    input  rv_core_pkg::wb_t     mem_fwd,
    input  rv_core_pkg::wb_t     wb_fwd,
    output rv_core_pkg::ex_mem_t ex_mem
);
    import rv_core_pkg::*;

    word_t      rs1_val;
    word_t      rs2_val;
    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    word_t      alu_result;
    ex_mem_t    ex_mem_d;

    // Newest producer wins, MEM before WB
    function automatic word_t fwd_select(
        input reg_addr_t rs,
        input word_t     reg_data,
        input wb_t       from_mem,
        input wb_t       from_wb
    );
        word_t val;
        if (from_mem.valid && from_mem.rd == rs) begin
            val = from_mem.data;
        end else if (from_wb.valid && from_wb.rd == rs) begin
            val = from_wb.data;
        end else begin
            val = reg_data;
        end
        return val;
    endfunction

    assign rs1_val = fwd_select(id_ex.rs1, id_ex.rs1_data, mem_fwd, wb_fwd);
    assign rs2_val = fwd_select(id_ex.rs2, id_ex.rs2_data, mem_fwd, wb_fwd);

    assign op_a  = (id_ex.ctrl.src_a_sel == SRC_A_ZERO) ? '0 : rs1_val;
    assign op_b  = (id_ex.ctrl.src_b_sel == SRC_B_IMM) ? id_ex.imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_result = word_t'(op_a < op_b);
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = word_t'($signed(op_a) >>> shamt);
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = '0;
        endcase
    end

    always_comb begin
        ex_mem_d.valid      = id_ex.valid;
        ex_mem_d.reg_write  = id_ex.ctrl.reg_write;
        ex_mem_d.mem_read   = id_ex.ctrl.mem_read;
        ex_mem_d.mem_write  = id_ex.ctrl.mem_write;
        ex_mem_d.mem_size   = id_ex.ctrl.mem_size;
        ex_mem_d.rd         = id_ex.rd;
        ex_mem_d.alu_result = alu_result;
        ex_mem_d.store_data = rs2_val;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_mem_d;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_memory_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_core_pkg::ex_mem_t ex_mem,
    output rv_core_pkg::wb_t     mem_fwd,
    output rv_core_pkg::wb_t     mem_wb
);
    import rv_core_pkg::*;

    word_t                        dmem [`RV_DMEM_WORDS];
    logic [`RV_DMEM_ADDR_BITS-1:0] word_idx;
    logic [1:0]                   byte_off;
    logic [3:0]                   wr_mask;
    word_t                        wr_data;
    logic [4:0]                   lane_shift;
    word_t                        rd_word;
    word_t                        rd_lane;
    word_t                        load_data;

    assign word_idx = ex_mem.alu_result[`RV_DMEM_ADDR_BITS+1:2];
    assign byte_off = ex_mem.alu_result[1:0];

    // Byte lanes, halfword ignores bit 0 and word ignores both
    always_comb begin
        case (ex_mem.mem_size[1:0])
            2'b00: begin
                wr_mask    = 4'b0001 << byte_off;
                wr_data    = {4{ex_mem.store_data[7:0]}};
                lane_shift = {byte_off, 3'b000};
            end
            2'b01: begin
                wr_mask    = byte_off[1] ? 4'b1100 : 4'b0011;
                wr_data    = {2{ex_mem.store_data[15:0]}};
                lane_shift = {byte_off[1], 4'b0000};
            end
            default: begin
                wr_mask    = 4'b1111;
                wr_data    = ex_mem.store_data;
                lane_shift = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (ex_mem.valid && ex_mem.mem_write) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_mask[b]) begin
                    dmem[word_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    assign rd_word = dmem[word_idx];
    assign rd_lane = rd_word >> lane_shift;

    // Bit 2 of mem_size selects zero extension
    always_comb begin
        case (ex_mem.mem_size[1:0])
            2'b00: begin
                load_data = ex_mem.mem_size[2] ? {24'b0, rd_lane[7:0]}
                                               : {{24{rd_lane[7]}}, rd_lane[7:0]};
            end
            2'b01: begin
                load_data = ex_mem.mem_size[2] ? {16'b0, rd_lane[15:0]}
                                               : {{16{rd_lane[15]}}, rd_lane[15:0]};
            end
            default: begin
                load_data = rd_lane;
            end
        endcase
    end

    always_comb begin
        mem_fwd.valid = ex_mem.valid && ex_mem.reg_write;
        mem_fwd.rd    = ex_mem.rd;
        mem_fwd.data  = ex_mem.mem_read ? load_data : ex_mem.alu_result;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= mem_fwd;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_register_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_core_pkg::reg_addr_t rs1_addr,
    input  rv_core_pkg::reg_addr_t rs2_addr,
    input  rv_core_pkg::wb_t       wr,
    output rv_core_pkg::word_t     rs1_data,
    output rv_core_pkg::word_t     rs2_data
);
    import rv_core_pkg::*;

    word_t regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wr.valid) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Write-through so a reader three behind sees the new value
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else if (wr.valid && wr.rd == rs1_addr) begin
            rs1_data = wr.data;
        end else begin
            rs1_data = regs[rs1_addr];
        end

        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else if (wr.valid && wr.rd == rs2_addr) begin
            rs2_data = wr.data;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

`default_nettype wire

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRAIN_LIMIT = 20;
    localparam int MEM_BYTES   = 4 * `RV_DMEM_WORDS;

    localparam logic [6:0] ENC_OP     = 7'b0110011;
    localparam logic [6:0] ENC_OP_IMM = 7'b0010011;
    localparam logic [6:0] ENC_LUI    = 7'b0110111;
    localparam logic [6:0] ENC_LOAD   = 7'b0000011;
    localparam logic [6:0] ENC_STORE  = 7'b0100011;

    // Each table entry owns a writeback slot due three falling edges after issue
    typedef struct packed {
        int          idx;
        int unsigned cycle;
        logic        wb;
        reg_addr_t   rd;
        word_t       data;
    } slot_t;

    logic      clk;
    logic      rst_n;
    logic      instr_valid;
    word_t     instr;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;

    string tbl_name [$];
    logic  tbl_valid [$];
    word_t tbl_instr [$];
    logic  tbl_wb [$];

    slot_t       pending [$];
    word_t       ref_regs [`RV_REG_COUNT];
    logic [7:0]  ref_mem [MEM_BYTES];
    int unsigned cyc = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          idle_errors = 0;
    logic        timed_out = 1'b0;

    rv_core uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic append_instr(input string name, input word_t ins, input logic wb);
        tbl_name.push_back(name);
        tbl_valid.push_back(1'b1);
        tbl_instr.push_back(ins);
        tbl_wb.push_back(wb);
    endtask

    // Random junk on instr while the strobe is low
    task automatic idle_slot(input string name);
        tbl_name.push_back(name);
        tbl_valid.push_back(1'b0);
        tbl_instr.push_back($urandom);
        tbl_wb.push_back(1'b0);
    endtask

    task automatic reg_op(input string name, input logic [6:0] f7, input logic [2:0] f3,
                          input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
        append_instr(name, {f7, rs2, rs1, f3, rd, ENC_OP}, rd != '0);
    endtask

    task automatic imm_op(input string name, input logic [2:0] f3, input reg_addr_t rd,
                          input reg_addr_t rs1, input logic [11:0] imm);
        append_instr(name, {imm, rs1, f3, rd, ENC_OP_IMM}, rd != '0);
    endtask

    task automatic load_op(input string name, input logic [2:0] f3, input reg_addr_t rd,
                           input reg_addr_t rs1, input logic [11:0] imm);
        append_instr(name, {imm, rs1, f3, rd, ENC_LOAD}, rd != '0);
    endtask

    task automatic store_op(input string name, input logic [2:0] f3, input reg_addr_t rs2,
                            input reg_addr_t rs1, input logic [11:0] imm);
        append_instr(name, {imm[11:5], rs2, rs1, f3, imm[4:0], ENC_STORE}, 1'b0);
    endtask

    // LUI takes the rounded upper part since ADDI sign-extends its immediate
    task automatic load_const(input string name, input reg_addr_t rd, input word_t value);
        word_t upper;
        upper = value + 32'h0000_0800;
        append_instr({name, "_lui"}, {upper[31:12], rd, ENC_LUI}, 1'b1);
        imm_op({name, "_addi"}, 3'd0, rd, rd, value[11:0]);
    endtask

    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        word_t res;
        case (f3)
            3'd0:    res = alt ? a - b : a + b;
            3'd1:    res = a << b[4:0];
            3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    res = (a < b) ? 32'd1 : 32'd0;
            3'd4:    res = a ^ b;
            3'd5:    res = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // Little endian with the low address bits dropped for halfword and word
    function automatic word_t load_model(input logic [2:0] f3, input int unsigned addr);
        int unsigned h;
        int unsigned w;
        word_t       val;
        h = addr & ~32'd1;
        w = addr & ~32'd3;
        case (f3[1:0])
            2'b00:   val = {{24{ref_mem[addr][7] & ~f3[2]}}, ref_mem[addr]};
            2'b01:   val = {{16{ref_mem[h + 1][7] & ~f3[2]}}, ref_mem[h + 1], ref_mem[h]};
            default: val = {ref_mem[w + 3], ref_mem[w + 2], ref_mem[w + 1], ref_mem[w]};
        endcase
        return val;
    endfunction

    task automatic store_model(input logic [2:0] f3, input int unsigned addr, input word_t d);
        int unsigned h;
        int unsigned w;
        h = addr & ~32'd1;
        w = addr & ~32'd3;
        case (f3[1:0])
            2'b00: ref_mem[addr] = d[7:0];
            2'b01: begin
                ref_mem[h]     = d[7:0];
                ref_mem[h + 1] = d[15:8];
            end
            default: begin
                for (int k = 0; k < 4; k++) begin
                    ref_mem[w + k] = d[8*k +: 8];
                end
            end
        endcase
    endtask

    task automatic exec_model(input word_t ins, output word_t result);
        reg_addr_t   rd;
        logic [2:0]  f3;
        word_t       a;
        word_t       b;
        word_t       imm_i;
        word_t       imm_s;
        int unsigned addr;
        rd     = ins[11:7];
        f3     = ins[14:12];
        a      = ref_regs[ins[19:15]];
        b      = ref_regs[ins[24:20]];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        imm_s  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        result = '0;
        case (ins[6:0])
            ENC_OP:     result = alu_model(f3, ins[30], a, b);
            ENC_OP_IMM: result = alu_model(f3, f3 == 3'd5 && ins[30], a, imm_i);
            ENC_LUI:    result = {ins[31:12], 12'b0};
            ENC_LOAD: begin
                addr   = (a + imm_i) % MEM_BYTES;
                result = load_model(f3, addr);
            end
            ENC_STORE: begin
                addr = (a + imm_s) % MEM_BYTES;
                store_model(f3, addr, b);
            end
            default: result = '0;
        endcase
        if (rd != '0 && ins[6:0] inside {ENC_OP, ENC_OP_IMM, ENC_LUI, ENC_LOAD}) begin
            ref_regs[rd] = result;
        end
    endtask

    // Called on every falling edge when the DUT outputs are settled
    task automatic check_slot();
        slot_t s;
        logic  ok;
        if (pending.size() > 0 && pending[0].cycle == cyc) begin
            s  = pending.pop_front();
            ok = 1'b1;
            assert (wb_valid == s.wb) else begin
                $display("CHECK FAILED %s: wb_valid expected %0b actual %0b",
                         tbl_name[s.idx], s.wb, wb_valid);
                ok = 1'b0;
            end
            if (s.wb && wb_valid) begin
                assert (wb_rd == s.rd) else begin
                    $display("CHECK FAILED %s: wb_rd expected x%0d actual x%0d",
                             tbl_name[s.idx], s.rd, wb_rd);
                    ok = 1'b0;
                end
                assert (wb_data == s.data) else begin
                    $display("CHECK FAILED %s: wb_data expected 0x%08h actual 0x%08h",
                             tbl_name[s.idx], s.data, wb_data);
                    ok = 1'b0;
                end
            end
            if (ok) begin
                tests_passed++;
                $display("PASS %s", tbl_name[s.idx]);
            end else begin
                tests_failed++;
                $display("FAIL %s", tbl_name[s.idx]);
            end
        end else begin
            assert (!wb_valid) else begin
                $display("Writeback to x%0d appeared on a cycle where none was due", wb_rd);
                idle_errors++;
            end
        end
    endtask

    task automatic build_table();
        for (int k = 0; k < 4; k++) begin
            idle_slot($sformatf("idle_after_reset_%0d", k));
        end
        load_const("x1", 5'd1, $urandom);
        load_const("x2_negative", 5'd2, $urandom | 32'h8000_0000);
        load_const("x3_positive", 5'd3, $urandom & 32'h7fff_ffff);
        load_const("x4_shift", 5'd4, $urandom | 32'h0000_0001);
        imm_op("x8_base", 3'd0, 5'd8, 5'd0, 12'h100);

        reg_op("add", 7'h00, 3'd0, 5'd5, 5'd1, 5'd2);
        reg_op("sub", 7'h20, 3'd0, 5'd6, 5'd1, 5'd2);
        reg_op("sll", 7'h00, 3'd1, 5'd7, 5'd1, 5'd4);
        reg_op("slt_neg", 7'h00, 3'd2, 5'd9, 5'd2, 5'd3);
        reg_op("sltu_neg", 7'h00, 3'd3, 5'd10, 5'd2, 5'd3);
        reg_op("xor", 7'h00, 3'd4, 5'd11, 5'd1, 5'd2);
        reg_op("srl", 7'h00, 3'd5, 5'd12, 5'd2, 5'd4);
        reg_op("sra", 7'h20, 3'd5, 5'd13, 5'd2, 5'd4);
        reg_op("or", 7'h00, 3'd6, 5'd14, 5'd1, 5'd2);
        reg_op("and", 7'h00, 3'd7, 5'd15, 5'd1, 5'd2);
        imm_op("addi_neg", 3'd0, 5'd16, 5'd1, 12'hffb);
        imm_op("addi_bit10", 3'd0, 5'd17, 5'd1, 12'h400);
        imm_op("slti_neg", 3'd2, 5'd18, 5'd2, 12'h003);
        imm_op("sltiu_neg", 3'd3, 5'd19, 5'd3, 12'hfff);
        imm_op("xori", 3'd4, 5'd20, 5'd1, 12'h5a5);
        imm_op("ori", 3'd6, 5'd21, 5'd2, 12'h0f0);
        imm_op("andi", 3'd7, 5'd22, 5'd1, 12'h7ff);
        imm_op("slli", 3'd1, 5'd23, 5'd1, 12'h007);
        imm_op("srli", 3'd5, 5'd24, 5'd2, 12'h009);
        imm_op("srai", 3'd5, 5'd25, 5'd2, 12'h409);
        append_instr("lui", {20'habcde, 5'd26, ENC_LUI}, 1'b1);

        // Consumers one, two and three behind their producer
        imm_op("fwd_mem_producer", 3'd0, 5'd10, 5'd1, 12'h011);
        reg_op("fwd_mem_consumer", 7'h00, 3'd0, 5'd11, 5'd10, 5'd2);
        imm_op("fwd_wb_producer", 3'd4, 5'd12, 5'd2, 12'hfff);
        imm_op("fwd_wb_filler", 3'd0, 5'd13, 5'd3, 12'h001);
        reg_op("fwd_wb_consumer", 7'h20, 3'd0, 5'd14, 5'd12, 5'd1);
        imm_op("fwd_gap_producer", 3'd6, 5'd15, 5'd3, 12'h033);
        idle_slot("fwd_gap_bubble");
        reg_op("fwd_gap_consumer", 7'h00, 3'd7, 5'd16, 5'd15, 5'd1);
        imm_op("fwd_rf_producer", 3'd1, 5'd17, 5'd1, 12'h003);
        imm_op("fwd_rf_filler_a", 3'd0, 5'd18, 5'd3, 12'h002);
        imm_op("fwd_rf_filler_b", 3'd0, 5'd19, 5'd3, 12'h003);
        reg_op("fwd_rf_consumer", 7'h00, 3'd4, 5'd20, 5'd17, 5'd2);
        reg_op("fwd_both_sources", 7'h00, 3'd0, 5'd21, 5'd19, 5'd20);
        imm_op("fwd_old_value", 3'd0, 5'd22, 5'd1, 12'h001);
        imm_op("fwd_new_value", 3'd0, 5'd22, 5'd3, 12'h002);
        reg_op("fwd_newest_wins", 7'h00, 3'd0, 5'd23, 5'd22, 5'd0);

        store_op("sw_word0", 3'd2, 5'd1, 5'd8, 12'h000);
        load_op("lw_after_sw", 3'd2, 5'd5, 5'd8, 12'h000);
        store_op("sw_word1", 3'd2, 5'd3, 5'd8, 12'h004);
        store_op("sh_upper", 3'd1, 5'd2, 5'd8, 12'h006);
        load_op("lh_upper", 3'd1, 5'd6, 5'd8, 12'h006);
        load_op("lhu_upper", 3'd5, 5'd7, 5'd8, 12'h006);
        store_op("sb_byte5", 3'd0, 5'd2, 5'd8, 12'h005);
        load_op("lb_byte5", 3'd0, 5'd9, 5'd8, 12'h005);
        load_op("lbu_byte5", 3'd4, 5'd10, 5'd8, 12'h005);
        load_op("lw_merged", 3'd2, 5'd11, 5'd8, 12'h004);
        load_op("lh_low_word", 3'd1, 5'd12, 5'd8, 12'h002);
        load_op("lbu_byte3", 3'd4, 5'd13, 5'd8, 12'h003);
        load_op("lhu_misaligned", 3'd5, 5'd14, 5'd8, 12'h007);
        load_op("lw_misaligned", 3'd2, 5'd15, 5'd8, 12'h005);
        imm_op("byte_minus_128", 3'd0, 5'd16, 5'd0, 12'hf80);
        store_op("sb_negative", 3'd0, 5'd16, 5'd8, 12'h00c);
        load_op("lb_negative", 3'd0, 5'd17, 5'd8, 12'h00c);
        load_op("lbu_negative", 3'd4, 5'd18, 5'd8, 12'h00c);
        load_op("lw_for_use", 3'd2, 5'd19, 5'd8, 12'h000);
        reg_op("add_after_lw", 7'h00, 3'd0, 5'd20, 5'd19, 5'd2);
        imm_op("x22_base_plus_16", 3'd0, 5'd22, 5'd8, 12'h010);
        store_op("sh_neg_offset", 3'd1, 5'd1, 5'd22, 12'hff2);
        load_op("lhu_neg_offset", 3'd5, 5'd23, 5'd22, 12'hff2);
        load_op("lw_after_sh", 3'd2, 5'd24, 5'd8, 12'h000);

        imm_op("addi_x0", 3'd0, 5'd0, 5'd1, 12'h005);
        reg_op("add_x0", 7'h00, 3'd0, 5'd0, 5'd1, 5'd2);
        reg_op("x0_reads_zero", 7'h00, 3'd6, 5'd25, 5'd0, 5'd3);
        load_op("lw_x0", 3'd2, 5'd0, 5'd8, 12'h000);
        append_instr("jal_unsupported", 32'h0040_00ef, 1'b0);
        // AUIPC to x5 must leave x5 alone
        append_instr("auipc_unsupported", 32'h1234_5297, 1'b0);
        reg_op("x5_unchanged", 7'h00, 3'd0, 5'd26, 5'd5, 5'd0);
        idle_slot("idle_end");
    endtask

    initial begin
        word_t result;
        word_t ins;
        slot_t s;
        int    wait_cycles;

        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        void'($urandom(32'h5f2d_a7e5));
        for (int r = 0; r < `RV_REG_COUNT; r++) begin
            ref_regs[r] = '0;
        end
        build_table();

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < tbl_name.size(); i++) begin
            @(negedge clk);
            check_slot();
            ins         = tbl_instr[i];
            instr_valid = tbl_valid[i];
            instr       = ins;
            s.idx       = i;
            s.cycle     = cyc + 3;
            s.wb        = tbl_wb[i];
            s.rd        = ins[11:7];
            s.data      = '0;
            if (tbl_valid[i]) begin
                exec_model(ins, result);
                s.data = result;
            end
            pending.push_back(s);
        end

        wait_cycles = 0;
        while (pending.size() > 0 && wait_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            check_slot();
            instr_valid = 1'b0;
            wait_cycles++;
        end
        if (pending.size() > 0) begin
            timed_out = 1'b1;
            $display("Timeout: %0d writeback slots never came due", pending.size());
        end

        $display("Tests: %0d passed, %0d failed, %0d stray writebacks",
                 tests_passed, tests_failed, idle_errors);
        if (tests_failed == 0 && idle_errors == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the rv_core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/rv_core_sim

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module rv_core_tb -Mdir obj_dir -o rv_core_sim -f rv_core.f; then
    echo "Verilator build failed"
    exit 1
fi

"./$SIM" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1

// ==== rv_core.f ====
+incdir+design
design/rv_core_pkg.sv
design/rv_register_file.sv
design/rv_decode_stage.sv
design/rv_execute_stage.sv
design/rv_memory_stage.sv
design/rv_core.sv
dv/rv_core_tb.sv
